// File: design/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Bus widths
`define MEM_ADDR_W      32
`define MEM_DATA_W      32

// Instruction cache geometry
`define LINE_WORDS      4
`define IC_LINES        8

// Address map
`define PERIPH_BASE     32'h1000_0000
`define EXT_FIFO_ADDR   32'hE000_1030

`endif

// File: design/bus_pkg.sv
`include "mem_config.svh"

package bus_pkg;

    typedef logic [`MEM_ADDR_W-1:0]               addr_t;
    typedef logic [`MEM_DATA_W-1:0]               word_t;
    typedef logic [`LINE_WORDS*`MEM_DATA_W-1:0]   line_t;
    typedef logic [`MEM_DATA_W/8-1:0]             strb_t;

    // One request on the shared memory bus
    typedef struct packed {
        addr_t addr;
        logic  we;
        word_t wdata;
        strb_t wstrb;
    } mem_cmd_t;

endpackage

// File: design/core_pkg.sv
package core_pkg;

    typedef enum logic {
        DAT_READ  = 1'b0,
        DAT_WRITE = 1'b1
    } dat_op_t;

    // Where a data access ends up
    typedef enum logic [1:0] {
        DEST_MEM  = 2'd0,
        DEST_PERI = 2'd1,
        DEST_FIFO = 2'd2
    } dat_dest_t;

endpackage

// File: design/icache.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module icache
(
    input  logic              CLK,
    input  logic              RSTN,
    input  logic              flush,
    input  logic              fetch_req,
    input  bus_pkg::addr_t    fetch_addr,
    output logic              fetch_ack,
    output bus_pkg::word_t    fetch_data,
    output logic              bus_req,
    output bus_pkg::mem_cmd_t bus_cmd,
    input  logic              bus_ack,
    input  bus_pkg::line_t    bus_rdata
);
    import bus_pkg::*;

    localparam int BYTE_W = $clog2(`MEM_DATA_W / 8);
    localparam int OFF_W  = $clog2(`LINE_WORDS * `MEM_DATA_W / 8);
    localparam int IDX_W  = $clog2(`IC_LINES);
    localparam int TAG_W  = `MEM_ADDR_W - OFF_W - IDX_W;

    typedef enum logic [2:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_REFILL_REQ,
        IC_REFILL_REL,
        IC_ACK
    } ic_state_t;

    ic_state_t                state;
    addr_t                    req_addr;
    logic [`IC_LINES-1:0]     valid;
    logic [TAG_W-1:0]         tag_mem [`IC_LINES];
    line_t                    data_mem [`IC_LINES];

    logic [IDX_W-1:0]         idx;
    logic [TAG_W-1:0]         tag;
    logic [OFF_W-BYTE_W-1:0]  wsel;
    line_t                    rd_line;
    word_t                    rd_word;
    logic                     hit;

    assign idx     = req_addr[OFF_W +: IDX_W];
    assign tag     = req_addr[`MEM_ADDR_W-1 -: TAG_W];
    assign wsel    = req_addr[BYTE_W +: OFF_W-BYTE_W];
    assign rd_line = data_mem[idx];
    assign rd_word = rd_line[wsel*`MEM_DATA_W +: `MEM_DATA_W];
    assign hit     = valid[idx] && (tag_mem[idx] == tag);

    // Refill always reads the aligned line
    assign bus_cmd = '{addr:  {req_addr[`MEM_ADDR_W-1:OFF_W], {OFF_W{1'b0}}},
                       we:    1'b0,
                       wdata: '0,
                       wstrb: '0};

    ////////////////////////////////////////////////////////////////////////////
    // Control
    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            state     <= IC_IDLE;
            fetch_ack <= 1'b0;
            bus_req   <= 1'b0;
            valid     <= '0;
        end
        else
        begin
            case (state)
                IC_IDLE:
                    if (fetch_req)
                        state <= IC_LOOKUP;
                IC_LOOKUP:
                    if (hit)
                    begin
                        fetch_ack <= 1'b1;
                        state     <= IC_ACK;
                    end
                    else
                    begin
                        bus_req <= 1'b1;
                        state   <= IC_REFILL_REQ;
                    end
                IC_REFILL_REQ:
                    if (bus_ack)
                    begin
                        bus_req    <= 1'b0;
                        valid[idx] <= 1'b1;
                        state      <= IC_REFILL_REL;
                    end
                IC_REFILL_REL:
                    // Answer once memory has let go of ack
                    if (!bus_ack)
                    begin
                        fetch_ack <= 1'b1;
                        state     <= IC_ACK;
                    end
                IC_ACK:
                    if (!fetch_req)
                    begin
                        fetch_ack <= 1'b0;
                        state     <= IC_IDLE;
                    end
                default:
                    state <= IC_IDLE;
            endcase
            // Fence
            if (flush)
                valid <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag, line and answer storage
    always_ff @(posedge CLK)
    begin
        if (state == IC_IDLE && fetch_req)
            req_addr <= fetch_addr;
        if (state == IC_REFILL_REQ && bus_ack)
        begin
            data_mem[idx] <= bus_rdata;
            tag_mem[idx]  <= tag;
        end
        if ((state == IC_LOOKUP && hit) || (state == IC_REFILL_REL && !bus_ack))
            fetch_data <= rd_word;
    end

endmodule

// File: design/dat_router.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module dat_router
(
    input  logic               CLK,
    input  logic               RSTN,
    input  logic               dat_req,
    input  core_pkg::dat_op_t  dat_op,
    input  bus_pkg::addr_t     dat_addr,
    input  bus_pkg::word_t     dat_wdata,
    input  bus_pkg::strb_t     dat_wstrb,
    output logic               dat_ack,
    output bus_pkg::word_t     dat_rdata,
    output logic               peri_req,
    output logic               peri_we,
    output bus_pkg::addr_t     peri_addr,
    output bus_pkg::word_t     peri_wdata,
    output bus_pkg::strb_t     peri_wstrb,
    input  logic               peri_ack,
    input  bus_pkg::word_t     peri_rdata,
    output logic               fifo_wr_en,
    output bus_pkg::word_t     fifo_wr_data,
    output logic               bus_req,
    output bus_pkg::mem_cmd_t  bus_cmd,
    input  logic               bus_ack,
    input  bus_pkg::line_t     bus_rdata
);
    import bus_pkg::*;
    import core_pkg::*;

    localparam int BYTE_W = $clog2(`MEM_DATA_W / 8);
    localparam int OFF_W  = $clog2(`LINE_WORDS * `MEM_DATA_W / 8);

    typedef enum logic [2:0] {
        DR_IDLE,
        DR_DISPATCH,
        DR_WAIT,
        DR_RELEASE,
        DR_ACK
    } dr_state_t;

    dr_state_t  state;
    dat_op_t    op_q;
    addr_t      addr_q;
    word_t      wdata_q;
    strb_t      wstrb_q;
    word_t      rdata_q;
    dat_dest_t  dest;
    logic       slv_ack;
    word_t      mem_word;

    // FIFO address wins over the peripheral window
    always_comb
    begin
        if (op_q == DAT_WRITE && addr_q == `EXT_FIFO_ADDR)
            dest = DEST_FIFO;
        else if (addr_q >= `PERIPH_BASE)
            dest = DEST_PERI;
        else
            dest = DEST_MEM;
    end

    assign slv_ack  = (dest == DEST_PERI) ? peri_ack : bus_ack;
    assign mem_word = bus_rdata[addr_q[BYTE_W +: OFF_W-BYTE_W]*`MEM_DATA_W +: `MEM_DATA_W];

    assign dat_rdata    = rdata_q;
    assign peri_we      = (op_q == DAT_WRITE);
    assign peri_addr    = addr_q;
    assign peri_wdata   = wdata_q;
    assign peri_wstrb   = wstrb_q;
    assign fifo_wr_data = wdata_q;
    assign bus_cmd      = '{addr: addr_q, we: op_q == DAT_WRITE, wdata: wdata_q, wstrb: wstrb_q};

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            state      <= DR_IDLE;
            dat_ack    <= 1'b0;
            peri_req   <= 1'b0;
            bus_req    <= 1'b0;
            fifo_wr_en <= 1'b0;
        end
        else
        begin
            case (state)
                DR_IDLE:
                    if (dat_req)
                        state <= DR_DISPATCH;
                DR_DISPATCH:
                    case (dest)
                        DEST_FIFO:
                        begin
                            fifo_wr_en <= 1'b1;
                            dat_ack    <= 1'b1;
                            state      <= DR_ACK;
                        end
                        DEST_PERI:
                        begin
                            peri_req <= 1'b1;
                            state    <= DR_WAIT;
                        end
                        default:
                        begin
                            bus_req <= 1'b1;
                            state   <= DR_WAIT;
                        end
                    endcase
                DR_WAIT:
                    if (slv_ack)
                    begin
                        peri_req <= 1'b0;
                        bus_req  <= 1'b0;
                        state    <= DR_RELEASE;
                    end
                DR_RELEASE:
                    if (!slv_ack)
                    begin
                        dat_ack <= 1'b1;
                        state   <= DR_ACK;
                    end
                DR_ACK:
                begin
                    fifo_wr_en <= 1'b0;
                    if (!dat_req)
                    begin
                        dat_ack <= 1'b0;
                        state   <= DR_IDLE;
                    end
                end
                default:
                    state <= DR_IDLE;
            endcase
        end
    end

    // Access capture and read data
    always_ff @(posedge CLK)
    begin
        if (state == DR_IDLE && dat_req)
        begin
            op_q    <= dat_op;
            addr_q  <= dat_addr;
            wdata_q <= dat_wdata;
            wstrb_q <= dat_wstrb;
        end
        if (state == DR_WAIT && slv_ack)
            rdata_q <= (dest == DEST_PERI) ? peri_rdata : mem_word;
    end

endmodule

// File: design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
#(
    parameter type payload_t = logic
)
(
    input  logic     CLK,
    input  logic     RSTN,
    input  logic     ic_req,
    input  payload_t ic_cmd,
    output logic     ic_ack,
    input  logic     dr_req,
    input  payload_t dr_cmd,
    output logic     dr_ack,
    output logic     mem_req,
    output payload_t mem_cmd,
    input  logic     mem_ack
);

    logic gnt_valid;
    logic gnt_dr;
    logic sel_req;

    assign sel_req = gnt_dr ? dr_req : ic_req;
    assign mem_cmd = gnt_dr ? dr_cmd : ic_cmd;

    // Ack goes straight back to the owner of the grant
    assign dr_ack = gnt_valid &&  gnt_dr && mem_ack;
    assign ic_ack = gnt_valid && !gnt_dr && mem_ack;

    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            gnt_valid <= 1'b0;
            gnt_dr    <= 1'b0;
            mem_req   <= 1'b0;
        end
        else if (!gnt_valid)
        begin
            // Data side first
            if ((dr_req || ic_req) && !mem_req && !mem_ack)
            begin
                gnt_valid <= 1'b1;
                gnt_dr    <= dr_req;
                mem_req   <= 1'b1;
            end
        end
        else
        begin
            mem_req <= sel_req;
            // Release phase done
            if (!sel_req && !mem_ack)
                gnt_valid <= 1'b0;
        end
    end

endmodule

// File: design/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
(
    input  logic               CLK,
    input  logic               RSTN,
    input  logic               flush,
    input  logic               fetch_req,
    input  bus_pkg::addr_t     fetch_addr,
    output logic               fetch_ack,
    output bus_pkg::word_t     fetch_data,
    input  logic               dat_req,
    input  core_pkg::dat_op_t  dat_op,
    input  bus_pkg::addr_t     dat_addr,
    input  bus_pkg::word_t     dat_wdata,
    input  bus_pkg::strb_t     dat_wstrb,
    output logic               dat_ack,
    output bus_pkg::word_t     dat_rdata,
    output logic               peri_req,
    output logic               peri_we,
    output bus_pkg::addr_t     peri_addr,
    output bus_pkg::word_t     peri_wdata,
    output bus_pkg::strb_t     peri_wstrb,
    input  logic               peri_ack,
    input  bus_pkg::word_t     peri_rdata,
    output logic               fifo_wr_en,
    output bus_pkg::word_t     fifo_wr_data,
    output logic               mem_req,
    output bus_pkg::mem_cmd_t  mem_cmd,
    input  logic               mem_ack,
    input  bus_pkg::line_t     mem_rdata
);
    import bus_pkg::*;

    logic     ic_req;
    logic     ic_ack;
    mem_cmd_t ic_cmd;
    logic     dr_req;
    logic     dr_ack;
    mem_cmd_t dr_cmd;

    icache u_icache
    (
        .CLK        (CLK),
        .RSTN       (RSTN),
        .flush      (flush),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .bus_req    (ic_req),
        .bus_cmd    (ic_cmd),
        .bus_ack    (ic_ack),
        .bus_rdata  (mem_rdata)
    );

    dat_router u_router
    (
        .CLK          (CLK),
        .RSTN         (RSTN),
        .dat_req      (dat_req),
        .dat_op       (dat_op),
        .dat_addr     (dat_addr),
        .dat_wdata    (dat_wdata),
        .dat_wstrb    (dat_wstrb),
        .dat_ack      (dat_ack),
        .dat_rdata    (dat_rdata),
        .peri_req     (peri_req),
        .peri_we      (peri_we),
        .peri_addr    (peri_addr),
        .peri_wdata   (peri_wdata),
        .peri_wstrb   (peri_wstrb),
        .peri_ack     (peri_ack),
        .peri_rdata   (peri_rdata),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .bus_req      (dr_req),
        .bus_cmd      (dr_cmd),
        .bus_ack      (dr_ack),
        .bus_rdata    (mem_rdata)
    );

    // Both clients share the one memory port
    bus_arbiter #(.payload_t(mem_cmd_t)) u_arbiter
    (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .ic_req  (ic_req),
        .ic_cmd  (ic_cmd),
        .ic_ack  (ic_ack),
        .dr_req  (dr_req),
        .dr_cmd  (dr_cmd),
        .dr_ack  (dr_ack),
        .mem_req (mem_req),
        .mem_cmd (mem_cmd),
        .mem_ack (mem_ack)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
    parameter real PERIOD = 4.0
)
(
    output logic CLK
);

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2.0) CLK = ~CLK;
    end

endmodule

// File: tb/tb_mem_model.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_model
(
    input  logic              CLK,
    input  logic              RSTN,
    input  logic              mem_req,
    input  bus_pkg::mem_cmd_t mem_cmd,
    output logic              mem_ack,
    output bus_pkg::line_t    mem_rdata,
    input  logic              peri_req,
    input  logic              peri_we,
    input  bus_pkg::addr_t    peri_addr,
    input  bus_pkg::word_t    peri_wdata,
    input  bus_pkg::strb_t    peri_wstrb,
    output logic              peri_ack,
    output bus_pkg::word_t    peri_rdata,
    input  logic              fifo_wr_en,
    input  bus_pkg::word_t    fifo_wr_data,
    output logic [31:0]       mem_rd_cnt,
    output logic [31:0]       mem_wr_cnt,
    output logic [31:0]       peri_cnt,
    output logic [31:0]       fifo_cnt,
    output bus_pkg::word_t    fifo_last
);
    import bus_pkg::*;

    word_t mem_words [addr_t];
    word_t peri_words [addr_t];
    logic  mem_busy;
    logic  peri_busy;
    int    mem_wait;
    int    peri_wait;

    function automatic word_t apply_strobes(input word_t old, input word_t wd, input strb_t st);
        word_t r;
        r = old;
        for (int b = 0; b < `MEM_DATA_W / 8; b++)
            if (st[b])
                r[b*8 +: 8] = wd[b*8 +: 8];
        return r;
    endfunction

    // Untouched words read as address xor A5A5_0000
    function automatic word_t read_word(input addr_t a);
        addr_t k;
        k = a >> 2;
        return mem_words.exists(k) ? mem_words[k] : ((k << 2) ^ 32'hA5A5_0000);
    endfunction

    function automatic word_t read_periph(input addr_t a);
        addr_t k;
        k = a >> 2;
        return peri_words.exists(k) ? peri_words[k] : ((k << 2) + 1);
    endfunction

    function automatic line_t read_line(input addr_t a);
        line_t l;
        addr_t base;
        base = a & ~addr_t'(`LINE_WORDS * `MEM_DATA_W / 8 - 1);
        for (int i = 0; i < `LINE_WORDS; i++)
            l[i*`MEM_DATA_W +: `MEM_DATA_W] = read_word(base + 4 * i);
        return l;
    endfunction

    initial
    begin
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        peri_ack   = 1'b0;
        peri_rdata = '0;
        mem_rd_cnt = '0;
        mem_wr_cnt = '0;
        peri_cnt   = '0;
        fifo_cnt   = '0;
        fifo_last  = '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory port
    always @(posedge CLK)
    begin
        if (!RSTN)
        begin
            mem_ack  <= 1'b0;
            mem_busy <= 1'b0;
        end
        else if (mem_ack)
        begin
            if (!mem_req)
                mem_ack <= 1'b0;
        end
        else if (mem_busy)
        begin
            if (mem_wait == 0)
            begin
                mem_busy <= 1'b0;
                mem_ack  <= 1'b1;
                if (mem_cmd.we)
                    mem_words[mem_cmd.addr >> 2] = apply_strobes(read_word(mem_cmd.addr),
                                                                 mem_cmd.wdata, mem_cmd.wstrb);
                else
                    mem_rdata <= read_line(mem_cmd.addr);
            end
            else
                mem_wait <= mem_wait - 1;
        end
        else if (mem_req)
        begin
            mem_busy <= 1'b1;
            mem_wait <= $urandom_range(0, 5);
            if (mem_cmd.we)
                mem_wr_cnt <= mem_wr_cnt + 1;
            else
                mem_rd_cnt <= mem_rd_cnt + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Peripheral port
    always @(posedge CLK)
    begin
        if (!RSTN)
        begin
            peri_ack  <= 1'b0;
            peri_busy <= 1'b0;
        end
        else if (peri_ack)
        begin
            if (!peri_req)
                peri_ack <= 1'b0;
        end
        else if (peri_busy)
        begin
            if (peri_wait == 0)
            begin
                peri_busy <= 1'b0;
                peri_ack  <= 1'b1;
                if (peri_we)
                    peri_words[peri_addr >> 2] = apply_strobes(read_periph(peri_addr),
                                                               peri_wdata, peri_wstrb);
                else
                    peri_rdata <= read_periph(peri_addr);
            end
            else
                peri_wait <= peri_wait - 1;
        end
        else if (peri_req)
        begin
            peri_busy <= 1'b1;
            peri_wait <= $urandom_range(0, 4);
            peri_cnt  <= peri_cnt + 1;
        end
    end

    // FIFO log
    always @(posedge CLK)
    begin
        if (fifo_wr_en)
        begin
            fifo_cnt  <= fifo_cnt + 1;
            fifo_last <= fifo_wr_data;
        end
    end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_top;
    import bus_pkg::*;
    import core_pkg::*;

    localparam int LINE_BYTES     = `LINE_WORDS * `MEM_DATA_W / 8;
    localparam int TIMEOUT_CYCLES = 300 * 40;

    logic        CLK;
    logic        RSTN;
    logic        flush;
    logic        fetch_req;
    addr_t       fetch_addr;
    logic        fetch_ack;
    word_t       fetch_data;
    logic        dat_req;
    dat_op_t     dat_op;
    addr_t       dat_addr;
    word_t       dat_wdata;
    strb_t       dat_wstrb;
    logic        dat_ack;
    word_t       dat_rdata;
    logic        peri_req;
    logic        peri_we;
    addr_t       peri_addr;
    word_t       peri_wdata;
    strb_t       peri_wstrb;
    logic        peri_ack;
    word_t       peri_rdata;
    logic        fifo_wr_en;
    word_t       fifo_wr_data;
    logic        mem_req;
    mem_cmd_t    mem_cmd;
    logic        mem_ack;
    line_t       mem_rdata;
    logic [31:0] mem_rd_cnt;
    logic [31:0] mem_wr_cnt;
    logic [31:0] peri_cnt;
    logic [31:0] fifo_cnt;
    word_t       fifo_last;

    // Reference state
    word_t                ref_mem [addr_t];
    word_t                ref_peri [addr_t];
    bit [`IC_LINES-1:0]   ic_valid = '0;
    int unsigned          ic_tag [`IC_LINES];
    int                   checks = 0;
    int                   errors = 0;
    int                   test_checks = 0;
    int                   test_errors = 0;
    int                   cycles = 0;

    tb_clock #(.PERIOD(4.0)) u_clock (.CLK(CLK));

    mem_subsys_top DUT
    (
        .CLK(CLK), .RSTN(RSTN), .flush(flush),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_ack(fetch_ack), .fetch_data(fetch_data),
        .dat_req(dat_req), .dat_op(dat_op), .dat_addr(dat_addr),
        .dat_wdata(dat_wdata), .dat_wstrb(dat_wstrb),
        .dat_ack(dat_ack), .dat_rdata(dat_rdata),
        .peri_req(peri_req), .peri_we(peri_we), .peri_addr(peri_addr),
        .peri_wdata(peri_wdata), .peri_wstrb(peri_wstrb),
        .peri_ack(peri_ack), .peri_rdata(peri_rdata),
        .fifo_wr_en(fifo_wr_en), .fifo_wr_data(fifo_wr_data),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    tb_mem_model u_mem
    (
        .CLK(CLK), .RSTN(RSTN),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .peri_req(peri_req), .peri_we(peri_we), .peri_addr(peri_addr),
        .peri_wdata(peri_wdata), .peri_wstrb(peri_wstrb),
        .peri_ack(peri_ack), .peri_rdata(peri_rdata),
        .fifo_wr_en(fifo_wr_en), .fifo_wr_data(fifo_wr_data),
        .mem_rd_cnt(mem_rd_cnt), .mem_wr_cnt(mem_wr_cnt),
        .peri_cnt(peri_cnt), .fifo_cnt(fifo_cnt), .fifo_last(fifo_last)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic word_t merge_bytes(input word_t old, input word_t wd, input strb_t st);
        word_t r;
        r = old;
        for (int b = 0; b < `MEM_DATA_W / 8; b++)
            if (st[b])
                r[b*8 +: 8] = wd[b*8 +: 8];
        return r;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        addr_t k;
        k = a >> 2;
        return ref_mem.exists(k) ? ref_mem[k] : ((k << 2) ^ 32'hA5A5_0000);
    endfunction

    function automatic word_t peri_word(input addr_t a);
        addr_t k;
        k = a >> 2;
        return ref_peri.exists(k) ? ref_peri[k] : ((k << 2) + 1);
    endfunction

    // Direct-mapped lookup that fills the line and returns 1 on a miss
    function automatic bit ic_access(input addr_t a);
        int unsigned line_no;
        int unsigned idx;
        bit          miss;
        line_no = a / LINE_BYTES;
        idx     = line_no % `IC_LINES;
        miss    = !(ic_valid[idx] && ic_tag[idx] == line_no);
        ic_valid[idx] = 1'b1;
        ic_tag[idx]   = line_no;
        return miss;
    endfunction

    // Four line regions spread over the instruction range
    function automatic addr_t fetch_address();
        return addr_t'($urandom_range(0, 3) << 10) | addr_t'($urandom_range(0, 31) << 2);
    endfunction

    function automatic addr_t data_address();
        return 32'h0000_1000 | addr_t'($urandom_range(0, 7) << 9)
                             | addr_t'($urandom_range(0, 7) << 2);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and bus tasks

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        test_checks++;
        if (exp !== act)
        begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic fetch(input addr_t a, output word_t d);
        fetch_req  <= 1'b1;
        fetch_addr <= a;
        @(posedge CLK);
        while (!fetch_ack)
            @(posedge CLK);
        d = fetch_data;
        fetch_req <= 1'b0;
        @(posedge CLK);
        while (fetch_ack)
            @(posedge CLK);
    endtask

    task automatic data_access(input dat_op_t op, input addr_t a, input word_t wd,
                               input strb_t st, output word_t rd);
        dat_req   <= 1'b1;
        dat_op    <= op;
        dat_addr  <= a;
        dat_wdata <= wd;
        dat_wstrb <= st;
        @(posedge CLK);
        while (!dat_ack)
            @(posedge CLK);
        rd = dat_rdata;
        dat_req <= 1'b0;
        @(posedge CLK);
        while (dat_ack)
            @(posedge CLK);
    endtask

    task automatic checked_fetch(input addr_t a, input bit count_reads);
        word_t       d;
        word_t       exp;
        logic [31:0] rd0;
        bit          miss;
        exp  = mem_word(a);
        miss = ic_access(a);
        rd0  = mem_rd_cnt;
        fetch(a, d);
        check("fetch_data", exp, d);
        if (count_reads)
            check("memory read count", rd0 + miss, mem_rd_cnt);
    endtask

    // Memory or peripheral access with the target picked from the address map
    task automatic checked_access(input dat_op_t op, input addr_t a, input word_t wd,
                                  input strb_t st);
        word_t rd;
        word_t exp;
        bit    to_peri;
        string name;
        to_peri = (a >= `PERIPH_BASE);
        exp     = to_peri ? peri_word(a) : mem_word(a);
        data_access(op, a, wd, st, rd);
        if (op == DAT_WRITE)
        begin
            if (to_peri)
                ref_peri[a >> 2] = merge_bytes(exp, wd, st);
            else
                ref_mem[a >> 2] = merge_bytes(exp, wd, st);
        end
        else
        begin
            if (to_peri)
                name = "dat_rdata (peripheral)";
            else
                name = "dat_rdata (memory)";
            check(name, exp, rd);
        end
    endtask

    task automatic flush_cache();
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(posedge CLK);
        ic_valid = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial
    begin
        logic [31:0] n_mem;
        logic [31:0] n_peri;
        logic [31:0] n_fifo;
        word_t       wd;
        word_t       rd;
        addr_t       fence_addr;

        void'($urandom(32'h4d6d5160));
        RSTN       = 1'b0;
        flush      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        dat_req    = 1'b0;
        dat_op     = DAT_READ;
        dat_addr   = '0;
        dat_wdata  = '0;
        dat_wstrb  = '0;
        repeat (3)
            @(posedge CLK);
        RSTN <= 1'b1;
        @(posedge CLK);

        repeat (100)
            checked_fetch(fetch_address(), 1'b1);
        end_test("random fetches");

        repeat (80)
            checked_access(dat_op_t'($urandom_range(0, 1)), data_address(), $urandom,
                           strb_t'($urandom_range(1, 15)));
        end_test("data memory");

        n_mem  = mem_rd_cnt + mem_wr_cnt;
        n_peri = peri_cnt;
        repeat (20)
            checked_access(dat_op_t'($urandom_range(0, 1)),
                           `PERIPH_BASE + addr_t'($urandom_range(0, 15) << 2), $urandom,
                           strb_t'($urandom_range(1, 15)));
        // A read of the FIFO address belongs to the peripheral window
        checked_access(DAT_READ, `EXT_FIFO_ADDR, '0, '0);
        check("memory requests", n_mem, mem_rd_cnt + mem_wr_cnt);
        check("peripheral requests", n_peri + 21, peri_cnt);
        end_test("peripheral routing");

        for (int i = 0; i < 10; i++)
        begin
            wd     = $urandom;
            n_fifo = fifo_cnt;
            n_mem  = mem_rd_cnt + mem_wr_cnt;
            n_peri = peri_cnt;
            data_access(DAT_WRITE, `EXT_FIFO_ADDR, wd, 4'hF, rd);
            check("fifo_wr_en pulses", n_fifo + 1, fifo_cnt);
            check("fifo_wr_data", wd, fifo_last);
            check("memory requests", n_mem, mem_rd_cnt + mem_wr_cnt);
            check("peripheral requests", n_peri, peri_cnt);
        end
        end_test("fifo writes");

        fork
            repeat (40)
                checked_fetch(fetch_address(), 1'b0);
            repeat (40)
                checked_access(dat_op_t'($urandom_range(0, 1)), data_address(), $urandom,
                               strb_t'($urandom_range(1, 15)));
        join
        end_test("concurrent traffic");

        fence_addr = 32'h0000_0240;
        checked_fetch(fence_addr, 1'b1);
        checked_access(DAT_WRITE, fence_addr, ~mem_word(fence_addr), 4'hF);
        flush_cache();
        checked_fetch(fence_addr, 1'b1);
        end_test("fence");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog
    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run stopped after %0d cycles with tests unfinished", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+design
design/bus_pkg.sv
design/core_pkg.sv
design/icache.sv
design/dat_router.sv
design/bus_arbiter.sv
design/mem_subsys_top.sv
tb/tb_clock.sv
tb/tb_mem_model.sv
tb/tb_top.sv
